//--- addr_gen.sv
// ======================================================================
// Indices show through a whole phase; strobes only follow step
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module addr_gen (
    input  mmctl_pkg::phase_t         phase,
    input  logic                      step,
    input  logic [mmctl_pkg::A_W-1:0] outer,
    input  logic [mmctl_pkg::A_W-1:0] inner,
    output mmctl_pkg::buf_port_t      buf_a,
    output mmctl_pkg::buf_port_t      buf_b,
    output mmctl_pkg::out_sel_t       out_sel
);
    import mmctl_pkg::*;

    always_comb begin
        buf_a   = '0;
        buf_b   = '0;
        out_sel = '0;
        case (phase)
            LOAD_A: begin
                buf_a.en    = step;
                buf_a.wr    = step;
                buf_a.idx_a = outer;              // a index
                buf_a.idx_b = inner[N_W-1:0];     // n index
            end
            LOAD_B: begin
                buf_b.en    = step;
                buf_b.wr    = step;
                buf_b.idx_a = outer;
                buf_b.idx_b = inner[M_W-1:0];     // m index
            end
            PROCESS: begin
                // Both buffers read at the wavefront step
                buf_a.en    = step;
                buf_a.idx_a = inner;
                buf_b.en    = step;
                buf_b.idx_a = inner;
            end
            SEND: begin
                out_sel.send = step;
                out_sel.row  = outer[N_W-1:0];
                out_sel.col  = inner[M_W-1:0];    // m fastest
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- compile.f
mmctl_pkg.sv
dim_check.sv
nested_counter.sv
mmctl_fsm.sv
addr_gen.sv
mm_controller.sv
tb_mm_controller.sv

//--- dim_check.sv
// ======================================================================
// Maximums must fit their fields; dims keeps the last legal command
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module dim_check #(
    parameter int A_MAX = 60000,
    parameter int M_MAX = 255,
    parameter int N_MAX = 255
) (
    input  logic                clk,
    input  logic                rst,
    input  mmctl_pkg::dim_cmd_t cmd,
    input  logic                capture,
    output logic                cmd_ok,
    output mmctl_pkg::dims_t    dims
);
    import mmctl_pkg::*;

    logic a_ok;
    logic m_ok;
    logic n_ok;

    // Each field in 1..MAX
    assign a_ok = (cmd.a != '0) && (int'(cmd.a) <= A_MAX);
    assign m_ok = (cmd.m != '0) && (int'(cmd.m) <= M_MAX);
    assign n_ok = (cmd.n != '0) && (int'(cmd.n) <= N_MAX);

    assign cmd_ok = a_ok && m_ok && n_ok;   // Same word as capture

    always_ff @(posedge clk) begin
        if (rst) begin
            dims <= '0;
        end else if (capture && cmd_ok) begin
            dims.a <= cmd.a;
            dims.m <= cmd.m;
            dims.n <= cmd.n;
        end
    end

endmodule

`default_nettype wire

//--- mm_controller.sv
// ======================================================================
// Maximums must be nonzero and fit the a, m and n fields
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module mm_controller #(
    parameter int A_MAX = 60000,
    parameter int M_MAX = 255,
    parameter int N_MAX = 255
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 valid,
    input  mmctl_pkg::dim_cmd_t  data_in,
    output logic                 err,
    output logic                 ready,
    output logic                 done,
    output mmctl_pkg::buf_port_t buf_a,
    output mmctl_pkg::buf_port_t buf_b,
    output mmctl_pkg::out_sel_t  out_sel
);
    import mmctl_pkg::*;

    logic           capture;
    logic           cmd_ok;
    dims_t          dims;
    logic           cnt_load;
    logic           cnt_step;
    logic           cnt_last;
    logic [A_W-1:0] outer_last;
    logic [A_W-1:0] inner_last;
    logic [A_W-1:0] outer;
    logic [A_W-1:0] inner;
    phase_t         phase;

    dim_check #(
        .A_MAX (A_MAX),
        .M_MAX (M_MAX),
        .N_MAX (N_MAX)
    ) u_dim_check (
        .clk     (clk),
        .rst     (rst),
        .cmd     (data_in),
        .capture (capture),
        .cmd_ok  (cmd_ok),
        .dims    (dims)
    );

    mmctl_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .valid      (valid),
        .cmd_ok     (cmd_ok),
        .dims       (dims),
        .cnt_last   (cnt_last),
        .capture    (capture),
        .cnt_load   (cnt_load),
        .cnt_step   (cnt_step),
        .outer_last (outer_last),
        .inner_last (inner_last),
        .phase      (phase),
        .err        (err),
        .ready      (ready),
        .done       (done)
    );

    nested_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (cnt_load),
        .outer_last (outer_last),
        .inner_last (inner_last),
        .step       (cnt_step),
        .outer      (outer),
        .inner      (inner),
        .last       (cnt_last)
    );

    addr_gen u_addr_gen (
        .phase   (phase),
        .step    (cnt_step),
        .outer   (outer),
        .inner   (inner),
        .buf_a   (buf_a),
        .buf_b   (buf_b),
        .out_sel (out_sel)
    );

endmodule

`default_nettype wire

//--- mmctl_fsm.sv
// ======================================================================
// Load and send hold on a low enable or valid; process ignores enable
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module mmctl_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  logic                      valid,
    input  logic                      cmd_ok,
    input  mmctl_pkg::dims_t          dims,
    input  logic                      cnt_last,
    output logic                      capture,
    output logic                      cnt_load,
    output logic                      cnt_step,
    output logic [mmctl_pkg::A_W-1:0] outer_last,
    output logic [mmctl_pkg::A_W-1:0] inner_last,
    output mmctl_pkg::phase_t         phase,
    output logic                      err,
    output logic                      ready,
    output logic                      done
);
    import mmctl_pkg::*;

    phase_t phase_q;
    phase_t phase_n;
    logic   entry_q;    // First cycle of a phase
    logic   done_q;
    logic   accept;     // One element moves this cycle

    // Dimensions widened to counter width
    logic [A_W-1:0] a_cnt;
    logic [A_W-1:0] m_cnt;
    logic [A_W-1:0] n_cnt;

    assign a_cnt  = dims.a;
    assign m_cnt  = A_W'(dims.m);
    assign n_cnt  = A_W'(dims.n);
    assign accept = enable && valid;

    // ==================================================================
    // Counter limits for the current phase
    // ==================================================================
    always_comb begin
        outer_last = '0;
        inner_last = '0;
        case (phase_q)
            LOAD_A: begin
                outer_last = a_cnt - A_W'(1);
                inner_last = n_cnt - A_W'(1);
            end
            LOAD_B: begin
                outer_last = a_cnt - A_W'(1);
                inner_last = m_cnt - A_W'(1);
            end
            PROCESS: begin
                inner_last = a_cnt + m_cnt + n_cnt - A_W'(3);   // a+m+n-2 steps
            end
            SEND: begin
                outer_last = n_cnt - A_W'(1);
                inner_last = m_cnt - A_W'(1);
            end
            default: ;
        endcase
    end

    // ==================================================================
    // Step and next phase
    // ==================================================================
    always_comb begin
        case (phase_q)
            LOAD_A, LOAD_B: cnt_step = accept;
            PROCESS:        cnt_step = 1'b1;
            SEND:           cnt_step = enable;
            default:        cnt_step = 1'b0;
        endcase
    end

    assign capture = (phase_q == IDLE) && accept;

    always_comb begin
        phase_n = phase_q;
        case (phase_q)
            IDLE: begin
                if (capture) begin
                    phase_n = cmd_ok ? LOAD_A : ERROR;
                end
            end
            ERROR: phase_n = IDLE;
            LOAD_A: begin
                if (cnt_step && cnt_last) begin
                    phase_n = LOAD_B;
                end
            end
            LOAD_B: begin
                if (cnt_step && cnt_last) begin
                    phase_n = PROCESS;
                end
            end
            PROCESS: begin
                if (cnt_last) begin
                    phase_n = SEND;
                end
            end
            SEND: begin
                if (cnt_step && cnt_last) begin
                    phase_n = IDLE;
                end
            end
            default: phase_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= IDLE;
            entry_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            phase_q <= phase_n;
            entry_q <= (phase_n != phase_q);
            done_q  <= (phase_q == SEND) && cnt_step && cnt_last;  // Pulse after last send
        end
    end

    assign cnt_load = entry_q;   // Restart counter on phase entry
    assign phase    = phase_q;
    assign err      = (phase_q == ERROR);
    assign ready    = (phase_q == IDLE) || (phase_q == LOAD_A) || (phase_q == LOAD_B);
    assign done     = done_q;

endmodule

`default_nettype wire

//--- mmctl_pkg.sv
// ======================================================================
// Field widths fix the largest job at a < 65536, m < 256 and n < 256
// ======================================================================
`default_nettype none

package mmctl_pkg;

    // ==================================================================
    // Field widths
    // ==================================================================
    localparam int A_W = 16;   // Shared dimension of A and B
    localparam int M_W = 8;    // Columns of B and of the result
    localparam int N_W = 8;    // Columns of A, rows of the result

    // ==================================================================
    // Command and latched dimensions
    // ==================================================================

    // Command word on data_in with a in the top half
    typedef struct packed {
        logic [A_W-1:0] a;     // Bits 31:16
        logic [M_W-1:0] m;     // Bits 15:8
        logic [N_W-1:0] n;     // Bits 7:0
    } dim_cmd_t;

    // Counts of the accepted job
    typedef struct packed {
        logic [A_W-1:0] a;
        logic [M_W-1:0] m;
        logic [N_W-1:0] n;
    } dims_t;

    // ==================================================================
    // Controller phases
    // ==================================================================
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        ERROR   = 3'd1,        // One cycle, err high
        LOAD_A  = 3'd2,
        LOAD_B  = 3'd3,
        PROCESS = 3'd4,        // Wavefront steps
        SEND    = 3'd5
    } phase_t;

    // ==================================================================
    // Control ports of the buffers and the serializer
    // ==================================================================

    // One buffer port where wr low means a read
    typedef struct packed {
        logic           en;
        logic           wr;
        logic [A_W-1:0] idx_a;   // Index along a
        logic [N_W-1:0] idx_b;   // n index on buffer A, m index on buffer B
    } buf_port_t;

    // Result element picked by the serializer
    typedef struct packed {
        logic           send;
        logic [N_W-1:0] row;     // n index
        logic [M_W-1:0] col;     // m index
    } out_sel_t;

endpackage

`default_nettype wire

//--- nested_counter.sv
// ======================================================================
// A load acts in its own cycle with zero indices and the new limits
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module nested_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic [mmctl_pkg::A_W-1:0] outer_last,
    input  logic [mmctl_pkg::A_W-1:0] inner_last,
    input  logic                      step,
    output logic [mmctl_pkg::A_W-1:0] outer,
    output logic [mmctl_pkg::A_W-1:0] inner,
    output logic                      last
);
    import mmctl_pkg::*;

    logic [A_W-1:0] outer_q;
    logic [A_W-1:0] inner_q;
    logic [A_W-1:0] olim_q;     // Stored limits
    logic [A_W-1:0] ilim_q;

    // Position and limits seen in this cycle
    logic [A_W-1:0] outer_eff;
    logic [A_W-1:0] inner_eff;
    logic [A_W-1:0] olim_eff;
    logic [A_W-1:0] ilim_eff;
    logic           inner_wrap;
    logic           outer_wrap;

    always_comb begin
        outer_eff = load ? '0 : outer_q;
        inner_eff = load ? '0 : inner_q;
        olim_eff  = load ? outer_last : olim_q;
        ilim_eff  = load ? inner_last : ilim_q;
    end

    assign inner_wrap = (inner_eff == ilim_eff);
    assign outer_wrap = (outer_eff == olim_eff);
    assign last       = inner_wrap && outer_wrap;   // Final position of the phase

    assign outer = outer_eff;
    assign inner = inner_eff;

    // ==================================================================
    // Index update, inner runs fastest
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            outer_q <= '0;
            inner_q <= '0;
            olim_q  <= '0;
            ilim_q  <= '0;
        end else begin
            if (load) begin
                olim_q <= outer_last;
                ilim_q <= inner_last;
            end
            if (step && inner_wrap) begin
                inner_q <= '0;
                outer_q <= outer_wrap ? '0 : outer_eff + A_W'(1);  // Back to 0,0 at the end
            end else if (step) begin
                inner_q <= inner_eff + A_W'(1);
                outer_q <= outer_eff;
            end else begin
                inner_q <= inner_eff;   // Hold
                outer_q <= outer_eff;
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_mm_controller -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep "Test completed successfully" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb_mm_controller.sv
// ======================================================================
// Runs with A_MAX 12, M_MAX 6 and N_MAX 5; every wait gives up on timeout
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module tb_mm_controller;
    import mmctl_pkg::*;

    logic      clk;
    logic      rst;
    logic      enable;
    logic      valid;
    dim_cmd_t  data_in;
    logic      err;
    logic      ready;
    logic      done;
    buf_port_t buf_a;
    buf_port_t buf_b;
    out_sel_t  out_sel;

    int          errors;
    int          jobs;
    bit          job_active;
    bit          last_send_q;   // Previous cycle held the final send
    int          ja;            // Dimensions of the running job
    int          jm;
    int          jn;
    int          a_cnt;
    int          b_cnt;
    int          rd_cnt;
    int          send_cnt;
    int          done_cnt;
    logic [31:0] rnd_state;

    mm_controller #(.A_MAX(12), .M_MAX(6), .N_MAX(5)) u_dut (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .valid   (valid),
        .data_in (data_in),
        .err     (err),
        .ready   (ready),
        .done    (done),
        .buf_a   (buf_a),
        .buf_b   (buf_b),
        .out_sel (out_sel)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expect_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Write strobes only when both handshakes are high
    strobe_needs_accept: assert property (@(posedge clk) disable iff (rst)
        (buf_a.wr || buf_b.wr) |-> (enable && valid))
        else begin
            errors++;
            $display("Write strobe seen while enable or valid was low");
        end

    // ==================================================================
    // Monitor that checks every cycle against its own counts
    // ==================================================================
    always @(posedge clk) begin
        if (!rst) begin
            expect_eq("done", int'(done), int'(last_send_q));
            last_send_q = 1'b0;
            if (!job_active) begin
                expect_eq("buf_a.en", int'(buf_a.en), 0);
                expect_eq("buf_b.en", int'(buf_b.en), 0);
                expect_eq("out_sel.send", int'(out_sel.send), 0);
            end else begin
                if (a_cnt < ja * jn) begin
                    expect_eq("buf_b.en", int'(buf_b.en), 0);   // B silent while A loads
                end
                if (buf_a.en && buf_a.wr) begin
                    expect_eq("buf_a.idx_a", int'(buf_a.idx_a), a_cnt / jn);
                    expect_eq("buf_a.idx_b", int'(buf_a.idx_b), a_cnt % jn);
                    expect_eq("ready", int'(ready), 1);
                    a_cnt++;
                end
                if (buf_a.en && !buf_a.wr) begin
                    expect_eq("b writes", b_cnt, ja * jm);
                    expect_eq("buf_b.en", int'(buf_b.en), 1);
                    expect_eq("buf_b.wr", int'(buf_b.wr), 0);
                    expect_eq("buf_a.idx_a", int'(buf_a.idx_a), rd_cnt);
                    expect_eq("buf_b.idx_a", int'(buf_b.idx_a), rd_cnt);
                    expect_eq("ready", int'(ready), 0);
                    rd_cnt++;
                end else if (b_cnt == ja * jm && rd_cnt < ja + jm + jn - 2) begin
                    errors++;
                    $display("Buffer reads did not run back to back after the last B write");
                end
                if (buf_b.en && buf_b.wr) begin
                    expect_eq("a writes", a_cnt, ja * jn);
                    expect_eq("buf_b.idx_a", int'(buf_b.idx_a), b_cnt / jm);
                    expect_eq("buf_b.idx_b", int'(buf_b.idx_b), b_cnt % jm);
                    expect_eq("ready", int'(ready), 1);
                    b_cnt++;
                end
                if (out_sel.send) begin
                    expect_eq("enable", int'(enable), 1);
                    expect_eq("reads", rd_cnt, ja + jm + jn - 2);
                    expect_eq("out_sel.row", int'(out_sel.row), send_cnt / jm);
                    expect_eq("out_sel.col", int'(out_sel.col), send_cnt % jm);
                    if (send_cnt == jn * jm - 1)
                        last_send_q = 1'b1;
                    send_cnt++;
                end
                if (done) begin
                    expect_eq("ready", int'(ready), 1);
                    done_cnt++;
                    job_active = 1'b0;
                end
            end
        end
    end

    task automatic bad_command(input int a, input int m, input int n);
        @(negedge clk);
        expect_eq("ready", int'(ready), 1);
        data_in = '{a: 16'(a), m: 8'(m), n: 8'(n)};
        enable  = 1'b1;
        valid   = 1'b1;
        @(negedge clk);
        expect_eq("err", int'(err), 1);   // Cycle after acceptance
        expect_eq("ready", int'(ready), 0);
        enable = 1'b0;
        valid  = 1'b0;
        @(negedge clk);
        expect_eq("err", int'(err), 0);
        expect_eq("ready", int'(ready), 1);
    endtask

    task automatic run_job(input int a, input int m, input int n);
        int cycles;
        @(negedge clk);
        ja = a;
        jm = m;
        jn = n;
        a_cnt = 0;
        b_cnt = 0;
        rd_cnt = 0;
        send_cnt = 0;
        done_cnt = 0;
        job_active = 1'b1;
        data_in = '{a: 16'(a), m: 8'(m), n: 8'(n)};
        enable  = 1'b1;
        valid   = 1'b1;
        cycles  = 0;
        while (job_active && cycles < 5000) begin
            @(negedge clk);
            data_in   = '0;
            rnd_state = xorshift(rnd_state);
            enable    = (rnd_state[1:0] != 2'b00);
            // Valid stays low once sending so that no command slips in after done
            valid     = (rnd_state[5:4] != 2'b00) && (rd_cnt < a + m + n - 2);
            cycles++;
        end
        enable = 1'b0;
        valid  = 1'b0;
        if (job_active) begin
            $display("Timeout waiting for done of a %0dx%0dx%0d job", a, m, n);
            $display("Test failed");
            $finish;
        end
        expect_eq("a writes", a_cnt, a * n);
        expect_eq("b writes", b_cnt, a * m);
        expect_eq("reads", rd_cnt, a + m + n - 2);
        expect_eq("sends", send_cnt, n * m);
        expect_eq("done pulses", done_cnt, 1);
        jobs++;
    endtask

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        errors      = 0;
        jobs        = 0;
        job_active  = 1'b0;
        last_send_q = 1'b0;
        rnd_state   = 32'd73;
        ja = 1;
        jm = 1;
        jn = 1;
        rst     = 1'b1;
        enable  = 1'b0;
        valid   = 1'b0;
        data_in = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        expect_eq("ready", int'(ready), 1);
        expect_eq("err", int'(err), 0);
        bad_command(0, 3, 2);
        bad_command(3, 7, 2);
        bad_command(3, 4, 6);
        bad_command(13, 1, 1);
        run_job(3, 4, 2);
        run_job(12, 6, 5);   // Largest legal job
        repeat (3) @(negedge clk);
        $display("Closing: %0d errors, %0d jobs completed", errors, jobs);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
